/* logic/cacheGeomPkg.sv */
package cacheGeomPkg;

  // core data width
  localparam int XLEN = 64;

  // address splits into tag, index, word and byte
  localparam int AddrWidth    = 32;
  localparam int TagWidth     = 21;
  localparam int IndexWidth   = 6;
  localparam int WordSelWidth = 2;
  localparam int ByteOffWidth = 3;

  localparam int Sets         = 2 ** IndexWidth;
  localparam int WordsPerLine = 2 ** WordSelWidth;
  localparam int Ways         = 2;

  typedef struct packed {
    logic [TagWidth-1:0]     tag;
    logic [IndexWidth-1:0]   index;
    logic [WordSelWidth-1:0] wordSel;
    logic [ByteOffWidth-1:0] byteOff;
  } addrFieldsT;

  // same 32 bits seen either as a plain address or as cache fields
  typedef union packed {
    logic [AddrWidth-1:0] raw;
    addrFieldsT           f;
  } cacheAddrT;

  // word 0 sits in the low 64 bits
  typedef logic [WordsPerLine-1:0][XLEN-1:0] lineT;

endpackage

/* logic/cachePipePkg.sv */
package cachePipePkg;

  import cacheGeomPkg::*;

  // snapshot of the set taken at accept time
  typedef struct packed {
    cacheAddrT                     addr;
    logic [Ways-1:0][TagWidth-1:0] tags;
    logic [Ways-1:0]               valid;
    logic                          lru;
    logic                          occupied;
  } lookupRespT;

  typedef struct packed {
    logic      start;
    cacheAddrT addr;
    logic      way;
  } missReqT;

  // whole-line fill from the miss engine
  typedef struct packed {
    logic                  we;
    logic [IndexWidth-1:0] index;
    logic                  way;
    logic [TagWidth-1:0]   tag;
    lineT                  line;
  } arrayWriteT;

  typedef struct packed {
    logic                  en;
    logic [IndexWidth-1:0] index;
    logic                  way;
  } lruUpdateT;

endpackage

/* logic/cacheLookup.sv */
module cacheLookup (
  input  logic                                     clk,
  input  logic                                     rst_n,
  input  logic                                     valid_i,
  input  cacheGeomPkg::cacheAddrT                  addr_i,
  input  logic                                     canAccept_i,
  input  cachePipePkg::lruUpdateT                  lruUpd_i,
  input  cachePipePkg::arrayWriteT                 arrayWr_i,
  output logic [cacheGeomPkg::IndexWidth-1:0]      readIndex_o,
  output logic                                     addrOk_o,
  output cachePipePkg::lookupRespT                 lookup_o
);

  import cacheGeomPkg::*;
  import cachePipePkg::*;

  logic [TagWidth-1:0]           tagArr [Ways][Sets];
  logic [Sets-1:0][Ways-1:0]     validArr;
  // lru bit names the way to evict next
  logic [Sets-1:0]               lruArr;

  logic                          accept;
  logic                          lruRead;
  logic                          occupied;
  cacheAddrT                     reqAddr;
  logic [Ways-1:0][TagWidth-1:0] respTags;
  logic [Ways-1:0]               respValid;
  logic                          respLru;

  assign accept      = valid_i && canAccept_i;
  assign readIndex_o = addr_i.f.index;

  // a hit retiring this cycle in the same set must be seen by the new request
  assign lruRead = (lruUpd_i.en && lruUpd_i.index == addr_i.f.index) ?
                   ~lruUpd_i.way : lruArr[addr_i.f.index];

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      validArr <= '0;
      lruArr   <= '0;
      addrOk_o <= 1'b0;
      occupied <= 1'b0;
    end else begin
      addrOk_o <= accept;
      if (canAccept_i) begin
        occupied <= valid_i;
      end else if (arrayWr_i.we) begin
        // refill served the stalled request
        occupied <= 1'b0;
      end
      if (lruUpd_i.en) begin
        lruArr[lruUpd_i.index] <= ~lruUpd_i.way;
      end
      if (arrayWr_i.we) begin
        validArr[arrayWr_i.index][arrayWr_i.way] <= 1'b1;
        lruArr[arrayWr_i.index] <= ~arrayWr_i.way;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (arrayWr_i.we) begin
      tagArr[arrayWr_i.way][arrayWr_i.index] <= arrayWr_i.tag;
    end
    if (accept) begin
      reqAddr   <= addr_i;
      respValid <= validArr[addr_i.f.index];
      respLru   <= lruRead;
      for (int w = 0; w < Ways; w++) begin
        respTags[w] <= tagArr[w][addr_i.f.index];
      end
    end
  end

  assign lookup_o = '{addr: reqAddr, tags: respTags, valid: respValid,
                      lru: respLru, occupied: occupied};

endmodule

/* logic/cacheDataArray.sv */
module cacheDataArray (
  input  logic                                clk,
  input  logic [cacheGeomPkg::IndexWidth-1:0] readIndex_i,
  input  logic                                readEn_i,
  input  cachePipePkg::arrayWriteT            arrayWr_i,
  output cacheGeomPkg::lineT                  wayLine0_o,
  output cacheGeomPkg::lineT                  wayLine1_o
);

  import cacheGeomPkg::*;

  // one line memory per way standing in for the SRAM macros
  lineT lineMem [Ways][Sets];

  // fill writes the whole line at once
  always_ff @(posedge clk) begin
    if (arrayWr_i.we) begin
      lineMem[arrayWr_i.way][arrayWr_i.index] <= arrayWr_i.line;
    end
  end

  // read data follows one edge after the index
  // outputs hold while the pipeline is stalled
  always_ff @(posedge clk) begin
    if (readEn_i) begin
      wayLine0_o <= lineMem[0][readIndex_i];
      wayLine1_o <= lineMem[1][readIndex_i];
    end
  end

endmodule

/* logic/cacheHitSelect.sv */
module cacheHitSelect (
  input  logic                          clk,
  input  logic                          rst_n,
  input  cachePipePkg::lookupRespT      lookup_i,
  input  cacheGeomPkg::lineT            wayLine0_i,
  input  cacheGeomPkg::lineT            wayLine1_i,
  input  logic                          refillDone_i,
  input  logic [cacheGeomPkg::XLEN-1:0] refillWord_i,
  output logic                          canAccept_o,
  output cachePipePkg::lruUpdateT       lruUpd_o,
  output cachePipePkg::missReqT         missReq_o,
  output logic                          dataOk_o,
  output logic [cacheGeomPkg::XLEN-1:0] rdData_o
);

  import cacheGeomPkg::*;

  logic [Ways-1:0] wayHit;
  logic            hit;
  logic            victimWay;
  logic            missPending;
  lineT            hitLine;

  for (genvar w = 0; w < Ways; w++) begin : gTagCmp
    assign wayHit[w] = lookup_i.valid[w] && (lookup_i.tags[w] == lookup_i.addr.f.tag);
  end

  assign hit     = lookup_i.occupied && (|wayHit);
  assign hitLine = wayHit[1] ? wayLine1_i : wayLine0_i;

  // empty way first, LRU way when the set is full
  assign victimWay = !lookup_i.valid[0] ? 1'b0 :
                     !lookup_i.valid[1] ? 1'b1 : lookup_i.lru;

  assign missReq_o = '{start: lookup_i.occupied && !(|wayHit) && !missPending,
                       addr: lookup_i.addr, way: victimWay};
  assign lruUpd_o  = '{en: hit, index: lookup_i.addr.f.index, way: wayHit[1]};

  assign canAccept_o = !lookup_i.occupied || (hit && !missPending);

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      missPending <= 1'b0;
      dataOk_o    <= 1'b0;
    end else begin
      dataOk_o <= hit || refillDone_i;
      if (refillDone_i) begin
        missPending <= 1'b0;
      end else if (missReq_o.start) begin
        missPending <= 1'b1;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (refillDone_i) begin
      rdData_o <= refillWord_i;
    end else if (hit) begin
      rdData_o <= hitLine[lookup_i.addr.f.wordSel];
    end
  end

endmodule

/* logic/cacheRefill.sv */
module cacheRefill (
  input  logic                               clk,
  input  logic                               rst_n,
  input  cachePipePkg::missReqT              missReq_i,
  input  logic                               memBeat_i,
  input  logic                               memRdLast_i,
  input  logic [cacheGeomPkg::XLEN-1:0]      memRdData_i,
  output logic                               memRdValid_o,
  output logic [cacheGeomPkg::AddrWidth-1:0] memAddr_o,
  output cachePipePkg::arrayWriteT           arrayWr_o,
  output logic                               refillDone_o,
  output logic [cacheGeomPkg::XLEN-1:0]      refillWord_o
);

  import cacheGeomPkg::*;

  localparam logic Idle  = 1'b0;
  localparam logic Fetch = 1'b1;

  logic                    state;
  logic [WordSelWidth-1:0] wordCnt;
  logic                    writeBack;
  logic                    lastBeat;
  cacheAddrT               reqAddr;
  logic                    victimWay;
  lineT                    lineBuf;
  lineT                    lineNext;

  // merge the incoming beat into the line being collected
  always_comb begin
    lineNext          = lineBuf;
    lineNext[wordCnt] = memRdData_i;
  end

  assign lastBeat = (state == Fetch) && memBeat_i && memRdLast_i;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state     <= Idle;
      wordCnt   <= '0;
      writeBack <= 1'b0;
    end else begin
      writeBack <= lastBeat;
      case (state)
        Idle: begin
          if (missReq_i.start) begin
            state   <= Fetch;
            wordCnt <= '0;
          end
        end
        Fetch: begin
          if (memBeat_i) begin
            wordCnt <= wordCnt + 1'b1;
            if (memRdLast_i) begin
              state <= Idle;
            end
          end
        end
        default: state <= Idle;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (state == Idle && missReq_i.start) begin
      reqAddr   <= missReq_i.addr;
      victimWay <= missReq_i.way;
    end
    if (state == Fetch && memBeat_i) begin
      lineBuf <= lineNext;
    end
  end

  // request stays up from the first fetch cycle until the last beat
  assign memRdValid_o = (state == Fetch);
  assign memAddr_o    = {reqAddr.f.tag, reqAddr.f.index,
                         {(WordSelWidth + ByteOffWidth){1'b0}}};

  // one cycle after the last beat the buffer is complete
  assign arrayWr_o = '{we: writeBack, index: reqAddr.f.index, way: victimWay,
                       tag: reqAddr.f.tag, line: lineBuf};

  assign refillDone_o = writeBack;
  assign refillWord_o = lineBuf[reqAddr.f.wordSel];

endmodule

/* logic/cacheTop.sv */
module cacheTop (
  input  logic                               clk,
  input  logic                               rst_n,
  input  logic                               valid_i,
  input  cacheGeomPkg::cacheAddrT            addr_i,
  output logic                               addrOk_o,
  output logic                               dataOk_o,
  output logic [cacheGeomPkg::XLEN-1:0]      rdData_o,
  output logic                               memRdValid_o,
  output logic [cacheGeomPkg::AddrWidth-1:0] memAddr_o,
  input  logic                               memBeat_i,
  input  logic                               memRdLast_i,
  input  logic [cacheGeomPkg::XLEN-1:0]      memRdData_i
);

  import cacheGeomPkg::*;
  import cachePipePkg::*;

  logic                  canAccept;
  logic                  refillDone;
  logic [XLEN-1:0]       refillWord;
  logic [IndexWidth-1:0] readIndex;
  lookupRespT            lookupResp;
  lruUpdateT             lruUpd;
  missReqT               missReq;
  arrayWriteT            arrayWr;
  lineT                  wayLine0;
  lineT                  wayLine1;

  cacheLookup uLookup (
    .clk         (clk),
    .rst_n       (rst_n),
    .valid_i     (valid_i),
    .addr_i      (addr_i),
    .canAccept_i (canAccept),
    .lruUpd_i    (lruUpd),
    .arrayWr_i   (arrayWr),
    .readIndex_o (readIndex),
    .addrOk_o    (addrOk_o),
    .lookup_o    (lookupResp)
  );

  // sets are read whenever stage one may take a request
  cacheDataArray uDataArray (
    .clk         (clk),
    .readIndex_i (readIndex),
    .readEn_i    (canAccept),
    .arrayWr_i   (arrayWr),
    .wayLine0_o  (wayLine0),
    .wayLine1_o  (wayLine1)
  );

  cacheHitSelect uHitSelect (
    .clk          (clk),
    .rst_n        (rst_n),
    .lookup_i     (lookupResp),
    .wayLine0_i   (wayLine0),
    .wayLine1_i   (wayLine1),
    .refillDone_i (refillDone),
    .refillWord_i (refillWord),
    .canAccept_o  (canAccept),
    .lruUpd_o     (lruUpd),
    .missReq_o    (missReq),
    .dataOk_o     (dataOk_o),
    .rdData_o     (rdData_o)
  );

  cacheRefill uRefill (
    .clk          (clk),
    .rst_n        (rst_n),
    .missReq_i    (missReq),
    .memBeat_i    (memBeat_i),
    .memRdLast_i  (memRdLast_i),
    .memRdData_i  (memRdData_i),
    .memRdValid_o (memRdValid_o),
    .memAddr_o    (memAddr_o),
    .arrayWr_o    (arrayWr),
    .refillDone_o (refillDone),
    .refillWord_o (refillWord)
  );

endmodule

/* test/cacheTbModel.svh */
`ifndef CACHE_TB_MODEL_SVH
`define CACHE_TB_MODEL_SVH

// stimulus generator state
logic [31:0] lfsr = 32'ha001_6647;

// reference copy of the tag store
logic [TagWidth-1:0] mTag [Sets][Ways];
logic [Ways-1:0]     mValid [Sets];
logic                mLru [Sets];

function automatic logic [31:0] lfsrNext(input logic [31:0] s);
  return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
endfunction

// one LFSR step per bit handed out
function automatic logic [31:0] takeBits(input int n);
  logic [31:0] r;
  r = '0;
  for (int i = 0; i < n; i++) begin
    lfsr = lfsrNext(lfsr);
    r = {r[30:0], lfsr[0]};
  end
  return r;
endfunction

// backing memory holds each word address next to its inverse
function automatic logic [XLEN-1:0] memWord(input logic [AddrWidth-1:0] a);
  logic [AddrWidth-1:0] w;
  w = {a[AddrWidth-1:ByteOffWidth], {ByteOffWidth{1'b0}}};
  return {w, ~w};
endfunction

function automatic void clearModel();
  for (int s = 0; s < Sets; s++) begin
    mValid[s] = '0;
    mLru[s] = 1'b0;
  end
endfunction

// returns 1 on a hit and updates the set in request order
function automatic logic predictAccess(input cacheAddrT a);
  logic [IndexWidth-1:0] idx;
  logic                  hit;
  logic                  way;
  idx = a.f.index;
  hit = 1'b0;
  way = mLru[idx];
  if (mValid[idx][0] && mTag[idx][0] == a.f.tag) begin
    hit = 1'b1;
    way = 1'b0;
  end else if (mValid[idx][1] && mTag[idx][1] == a.f.tag) begin
    hit = 1'b1;
    way = 1'b1;
  end else if (!mValid[idx][0]) begin
    way = 1'b0;
  end else if (!mValid[idx][1]) begin
    way = 1'b1;
  end
  if (!hit) begin
    mValid[idx][way] = 1'b1;
    mTag[idx][way] = a.f.tag;
  end
  // the other way becomes the next victim
  mLru[idx] = ~way;
  return hit;
endfunction

`endif

/* test/cacheTb.sv */
module cacheTb;

  import cacheGeomPkg::*;

  localparam int NumReqs    = 400;
  localparam int CycleLimit = NumReqs * 30;

  typedef struct packed {
    logic [AddrWidth-1:0] addr;
    logic                 miss;
    int                   acc;
  } reqT;

  logic                 clk = 1'b0;
  logic                 rst_n = 1'b0;
  logic                 valid_i = 1'b0;
  cacheAddrT            addr_i = '0;
  logic                 memBeat_i = 1'b0;
  logic                 memRdLast_i = 1'b0;
  logic [XLEN-1:0]      memRdData_i = '0;
  logic                 addrOk_o;
  logic                 dataOk_o;
  logic [XLEN-1:0]      rdData_o;
  logic                 memRdValid_o;
  logic [AddrWidth-1:0] memAddr_o;

  // values for the next rising edge
  logic                 nextValid = 1'b0;
  cacheAddrT            nextAddr = '0;
  logic                 nextBeat = 1'b0;
  logic                 nextLast = 1'b0;
  logic [XLEN-1:0]      nextData = '0;

  int                   cycle = 0;
  int                   errors = 0;
  int                   acceptCnt = 0;
  int                   beatsSent = 0;
  int                   gapLeft = 0;
  int                   expDone = -1;
  logic                 started = 1'b0;
  logic                 finished = 1'b0;
  logic                 pendingAccept = 1'b0;
  logic                 stall = 1'b0;
  logic                 prevMemValid = 1'b0;
  logic                 fetching = 1'b0;
  cacheAddrT            pendingAddr = '0;
  logic [AddrWidth-1:0] lineAddr = '0;
  reqT                  reqQ [$];

  `include "cacheTbModel.svh"

  cacheTop DUT (
    .clk          (clk),
    .rst_n        (rst_n),
    .valid_i      (valid_i),
    .addr_i       (addr_i),
    .addrOk_o     (addrOk_o),
    .dataOk_o     (dataOk_o),
    .rdData_o     (rdData_o),
    .memRdValid_o (memRdValid_o),
    .memAddr_o    (memAddr_o),
    .memBeat_i    (memBeat_i),
    .memRdLast_i  (memRdLast_i),
    .memRdData_i  (memRdData_i)
  );

  always #2 clk = ~clk;

  always @(posedge clk) begin
    cycle       <= cycle + 1;
    valid_i     <= nextValid;
    addr_i      <= nextAddr;
    memBeat_i   <= nextBeat;
    memRdLast_i <= nextLast;
    memRdData_i <= nextData;
  end

  task automatic compareValue(input string name, input logic [63:0] expVal,
                              input logic [63:0] actVal);
    assert (actVal === expVal)
      else begin
        errors++;
        $display("[FAIL] %0t %s expected %h got %h", $time, name, expVal, actVal);
      end
  endtask

  task automatic expectTrue(input logic cond, input string what);
    assert (cond)
      else begin
        errors++;
        $display("error at %0t: %s", $time, what);
      end
  endtask

  // few tags and sets so conflicts and evictions come often
  function automatic cacheAddrT pickAddr();
    cacheAddrT  a;
    logic [1:0] t;
    logic [1:0] s;
    t = 2'(takeBits(2));
    s = 2'(takeBits(2));
    case (t)
      2'd0: a.f.tag = 21'h00001;
      2'd1: a.f.tag = 21'h0abcd;
      2'd2: a.f.tag = 21'h15555;
      default: a.f.tag = 21'h1f00f;
    endcase
    case (s)
      2'd0: a.f.index = 6'd0;
      2'd1: a.f.index = 6'd7;
      2'd2: a.f.index = 6'd42;
      default: a.f.index = 6'd63;
    endcase
    a.f.wordSel = 2'(takeBits(2));
    a.f.byteOff = 3'(takeBits(3));
    return a;
  endfunction

  // outputs are sampled mid-cycle, inputs go out at the next rising edge
  always @(negedge clk) begin
    reqT  head;
    logic hit;
    logic memRise;
    logic missDue;
    int   due;
    if (rst_n && !started) begin
      compareValue("addrOk_o", 64'(0), 64'(addrOk_o));
      compareValue("dataOk_o", 64'(0), 64'(dataOk_o));
      compareValue("memRdValid_o", 64'(0), 64'(memRdValid_o));
      clearModel();
      started = 1'b1;
    end else if (started) begin
      // results retire in acceptance order
      if (dataOk_o) begin
        if (reqQ.size() == 0) begin
          expectTrue(1'b0, "dataOk_o pulsed with no request outstanding");
        end else begin
          head = reqQ.pop_front();
          due = head.miss ? expDone : head.acc + 1;
          compareValue("rdData_o", memWord(head.addr), rdData_o);
          compareValue("dataOk_o cycle", 64'(due), 64'(cycle));
          if (head.miss) begin
            expectTrue(!memRdValid_o, "memRdValid_o still high after the last beat");
            stall = 1'b0;
          end
        end
      end else if (reqQ.size() != 0) begin
        head = reqQ[0];
        due = head.miss ? expDone : head.acc + 1;
        expectTrue(cycle != due, "dataOk_o missing for a request that was due");
      end
      compareValue("addrOk_o", 64'(pendingAccept), 64'(addrOk_o));
      expectTrue(!(addrOk_o && prevMemValid), "request accepted during a refill");
      if (pendingAccept) begin
        hit = predictAccess(pendingAddr);
        reqQ.push_back('{addr: pendingAddr.raw, miss: !hit, acc: cycle});
        if (!hit) begin
          stall = 1'b1;
          expDone = -1;
        end
      end
      // memory responder
      memRise = memRdValid_o && !prevMemValid;
      missDue = reqQ.size() != 0 && reqQ[0].miss && cycle == reqQ[0].acc + 1;
      expectTrue(memRise == missDue, "memRdValid_o rise does not match a predicted miss");
      if (memRise) begin
        lineAddr = memAddr_o;
        if (reqQ.size() != 0) begin
          lineAddr = {reqQ[0].addr[AddrWidth-1:5], 5'b0};
          compareValue("memAddr_o", 64'(lineAddr), 64'(memAddr_o));
        end
        fetching = 1'b1;
        beatsSent = 0;
        gapLeft = int'(takeBits(2));
      end
      nextBeat = 1'b0;
      nextLast = 1'b0;
      nextData = '0;
      if (fetching && memRdValid_o && beatsSent < WordsPerLine) begin
        if (gapLeft == 0) begin
          nextBeat = 1'b1;
          nextLast = (beatsSent == WordsPerLine - 1);
          nextData = memWord(lineAddr + 32'(beatsSent * 8));
          beatsSent++;
          gapLeft = int'(takeBits(2));
          // beat goes out next edge, is sampled one later, result one after that
          if (nextLast) begin
            expDone = cycle + 3;
          end
        end else begin
          gapLeft--;
        end
      end
      if (!memRdValid_o) begin
        fetching = 1'b0;
      end
      prevMemValid = memRdValid_o;
      pendingAccept = valid_i && !stall;
      pendingAddr = addr_i;
      if (pendingAccept) begin
        acceptCnt++;
      end
      finished = acceptCnt >= NumReqs && !pendingAccept && reqQ.size() == 0 &&
                 !memRdValid_o;
    end
    if (started) begin
      nextValid = (acceptCnt < NumReqs) && (takeBits(2) != 0);
      nextAddr = pickAddr();
    end
  end

  initial begin
    repeat (3) @(posedge clk);
    rst_n <= 1'b1;
    while (!finished && cycle < CycleLimit) begin
      @(posedge clk);
    end
    if (!finished) begin
      $display("timeout: run did not complete within %0d cycles", CycleLimit);
    end else begin
      // quiet tail catches stray responses
      repeat (4) @(posedge clk);
    end
    $display("requests: %0d errors: %0d", acceptCnt, errors);
    if (!finished || errors != 0) begin
      $display("Simulation failed");
    end else begin
      $display("Simulation passed");
    end
    $finish;
  end

endmodule

/* flist.f */
logic/cacheGeomPkg.sv
logic/cachePipePkg.sv
logic/cacheLookup.sv
logic/cacheDataArray.sv
logic/cacheHitSelect.sv
logic/cacheRefill.sv
logic/cacheTop.sv
+incdir+test
test/cacheTb.sv

/* run.sh */
#!/bin/sh
# build and run the cache testbench with Verilator
cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -f flist.f --top-module cacheTb -Mdir obj_dir -o cacheSim
if [ $? -ne 0 ]; then
  echo "verilator build failed"
  exit 1
fi

./obj_dir/cacheSim > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if grep -q "Simulation failed" "$LOG"; then
  exit 1
fi
exit 0
